/* src/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Architectural register file size
`define RENAME_NUM_ARCH 16

// Physical register file size, also the free-list ring depth
`define RENAME_NUM_PHYS 32

// Index widths
`define RENAME_ARCH_W 4
`define RENAME_PHYS_W 5

// Free-list occupancy counter, one bit wider so a full ring fits
`define RENAME_CNT_W (`RENAME_PHYS_W + 1)

`endif

/* src/rename_pkg.sv */
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

  // Architectural register index
  typedef logic [`RENAME_ARCH_W-1:0] arch_idx_t;

  // Physical register index
  typedef logic [`RENAME_PHYS_W-1:0] phys_idx_t;

  // Controller state
  // ST_INIT runs the reset sweep, ST_RUN serves renames
  typedef enum logic {
    ST_INIT,
    ST_RUN
  } ctrl_state_e;

endpackage

`default_nettype wire

/* src/rename_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Link between the free list and the controller
interface free_list_if;
  logic                  push_valid;
  rename_pkg::phys_idx_t push_id;
  logic                  pop;
  rename_pkg::phys_idx_t head_id;
  logic                  empty;

  modport owner (
    input  push_valid,
    input  push_id,
    input  pop,
    output head_id,
    output empty
  );

  modport user (
    output push_valid,
    output push_id,
    output pop,
    input  head_id,
    input  empty
  );
endinterface

// Link between the map table and the controller
interface map_if;
  rename_pkg::arch_idx_t src1_arch;
  rename_pkg::arch_idx_t src2_arch;
  rename_pkg::arch_idx_t dst_arch;
  rename_pkg::phys_idx_t src1_phys;
  rename_pkg::phys_idx_t src2_phys;
  rename_pkg::phys_idx_t old_phys;
  logic                  wr_en;
  rename_pkg::arch_idx_t wr_arch;
  rename_pkg::phys_idx_t wr_phys;

  modport owner (
    input  src1_arch, src2_arch, dst_arch,
    output src1_phys, src2_phys, old_phys,
    input  wr_en, wr_arch, wr_phys
  );

  modport user (
    output src1_arch, src2_arch, dst_arch,
    input  src1_phys, src2_phys, old_phys,
    output wr_en, wr_arch, wr_phys
  );
endinterface

`default_nettype wire

/* src/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

// Circular FIFO of free physical register ids
// Ids leave from the head and come back at the tail in commit order
module free_list (
  input  logic      clk,
  input  logic      rst,
  free_list_if.owner fl
);

  rename_pkg::phys_idx_t     ring [`RENAME_NUM_PHYS];
  rename_pkg::phys_idx_t     head;
  rename_pkg::phys_idx_t     tail;
  logic [`RENAME_CNT_W-1:0]  count;
  logic                      full;

  // Ring depth is a power of two, pointers wrap on their own
  assign full       = (count == `RENAME_CNT_W'(`RENAME_NUM_PHYS));
  assign fl.empty   = (count == '0);
  assign fl.head_id = ring[head];

  // Storage, written at the tail
  always_ff @(posedge clk) begin
    if (fl.push_valid) begin
      ring[tail] <= fl.push_id;
    end
  end

  // Pointers
  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (fl.pop) begin
        head <= head + 1'b1;
      end
      if (fl.push_valid) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // Occupancy, unchanged when push and pop coincide
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({fl.push_valid, fl.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Controller must gate pop with empty
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (rst)
    fl.pop |-> !fl.empty
  ) else $error("free_list: pop while empty");

  // Only ids taken out may come back, so the ring never overflows
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (rst)
    (fl.push_valid && full) |-> fl.pop
  ) else $error("free_list: push while full");

endmodule

`default_nettype wire

/* src/map_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

// Architectural to physical register map
// Three combinational read ports, one clocked write port
module map_table (
  input  logic  clk,
  map_if.owner  fl_map
);

  rename_pkg::phys_idx_t map_mem [`RENAME_NUM_ARCH];

  // Reads see the mapping from before a same-cycle write
  assign fl_map.src1_phys = map_mem[fl_map.src1_arch];
  assign fl_map.src2_phys = map_mem[fl_map.src2_arch];
  assign fl_map.old_phys  = map_mem[fl_map.dst_arch];

  // Filled with the identity mapping by the reset sweep
  always_ff @(posedge clk) begin
    if (fl_map.wr_en) begin
      map_mem[fl_map.wr_arch] <= fl_map.wr_phys;
    end
  end

  // New mapping must name a real physical register, never an unknown id
  a_wr_known: assert property (
    @(posedge clk)
    fl_map.wr_en |-> !$isunknown(fl_map.wr_phys)
  ) else $error("map_table: write of unknown id");

endmodule

`default_nettype wire

/* src/init_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

// Walks the physical indices once after reset
module init_counter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enable,
  output rename_pkg::phys_idx_t index,
  output logic                  last
);

  // Final step of the sweep
  assign last = (index == rename_pkg::phys_idx_t'(`RENAME_NUM_PHYS - 1));

  // Stops at the final index and holds there
  always_ff @(posedge clk) begin
    if (rst) begin
      index <= '0;
    end else if (enable && !last) begin
      index <= index + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/rename_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

// Rename controller
// ST_INIT steers the sweep, ST_RUN serves one rename per clock
module rename_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  rename_pkg::arch_idx_t req_dst,
  input  rename_pkg::arch_idx_t req_src1,
  input  rename_pkg::arch_idx_t req_src2,
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output rename_pkg::phys_idx_t resp_src1_phys,
  output rename_pkg::phys_idx_t resp_src2_phys,
  output rename_pkg::phys_idx_t resp_new_phys,
  output rename_pkg::phys_idx_t resp_old_phys,
  input  logic                  release_valid,
  input  rename_pkg::phys_idx_t release_phys,
  output logic                  sweep_enable,
  input  rename_pkg::phys_idx_t sweep_index,
  input  logic                  sweep_last,
  free_list_if.user             fl,
  map_if.user                   mt
);

  rename_pkg::ctrl_state_e state;
  logic                    in_init;
  logic                    sweep_to_map;
  logic                    accept;

  assign in_init      = (state == rename_pkg::ST_INIT);
  assign sweep_enable = in_init;

  // Low sweep indices seed the map, the rest seed the free list
  assign sweep_to_map = (sweep_index < rename_pkg::phys_idx_t'(`RENAME_NUM_ARCH));

  // Accept only with a free id and room in the response register
  assign req_ready = !in_init && !fl.empty && (!resp_valid || resp_ready);
  assign accept    = req_valid && req_ready;

  // Free-list side
  assign fl.pop        = accept;
  assign fl.push_valid = in_init ? !sweep_to_map : release_valid;
  assign fl.push_id    = in_init ? sweep_index : release_phys;

  // Map-table side
  assign mt.src1_arch = req_src1;
  assign mt.src2_arch = req_src2;
  assign mt.dst_arch  = req_dst;
  assign mt.wr_en     = in_init ? sweep_to_map : accept;
  assign mt.wr_arch   = in_init ? sweep_index[`RENAME_ARCH_W-1:0] : req_dst;
  assign mt.wr_phys   = in_init ? sweep_index : fl.head_id;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rename_pkg::ST_INIT;
    end else if (in_init && sweep_last) begin
      state <= rename_pkg::ST_RUN;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else if (accept) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  // Response payload, old mapping sampled before the write lands
  always_ff @(posedge clk) begin
    if (accept) begin
      resp_src1_phys <= mt.src1_phys;
      resp_src2_phys <= mt.src2_phys;
      resp_new_phys  <= fl.head_id;
      resp_old_phys  <= mt.old_phys;
    end
  end

  // Commit cannot release before the sweep is done
  a_no_release_in_init: assert property (
    @(posedge clk) disable iff (rst)
    in_init |-> !release_valid
  ) else $error("rename_ctrl: release during init sweep");

  // A stalled response holds its payload
  a_resp_stable: assert property (
    @(posedge clk) disable iff (rst)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_new_phys))
  ) else $error("rename_ctrl: response changed under back-pressure");

endmodule

`default_nettype wire

/* src/rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Register rename stage, one rename per clock
module rename_top (
  input  logic                  clk,
  input  logic                  rst,

  // Rename request
  input  logic                  req_valid,
  output logic                  req_ready,
  input  rename_pkg::arch_idx_t req_dst,
  input  rename_pkg::arch_idx_t req_src1,
  input  rename_pkg::arch_idx_t req_src2,

  // Rename response
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output rename_pkg::phys_idx_t resp_src1_phys,
  output rename_pkg::phys_idx_t resp_src2_phys,
  output rename_pkg::phys_idx_t resp_new_phys,
  output rename_pkg::phys_idx_t resp_old_phys,

  // Commit release, always accepted once running
  input  logic                  release_valid,
  input  rename_pkg::phys_idx_t release_phys
);

  // Sweep counter link
  logic                  sweep_enable;
  rename_pkg::phys_idx_t sweep_index;
  logic                  sweep_last;

  free_list_if fl_if ();
  map_if       mt_if ();

  rename_ctrl rename_ctrl_inst (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_dst        (req_dst),
    .req_src1       (req_src1),
    .req_src2       (req_src2),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_src1_phys (resp_src1_phys),
    .resp_src2_phys (resp_src2_phys),
    .resp_new_phys  (resp_new_phys),
    .resp_old_phys  (resp_old_phys),
    .release_valid  (release_valid),
    .release_phys   (release_phys),
    .sweep_enable   (sweep_enable),
    .sweep_index    (sweep_index),
    .sweep_last     (sweep_last),
    .fl             (fl_if),
    .mt             (mt_if)
  );

  init_counter init_counter_inst (
    .clk    (clk),
    .rst    (rst),
    .enable (sweep_enable),
    .index  (sweep_index),
    .last   (sweep_last)
  );

  free_list free_list_inst (
    .clk (clk),
    .rst (rst),
    .fl  (fl_if)
  );

  map_table map_table_inst (
    .clk    (clk),
    .fl_map (mt_if)
  );

endmodule

`default_nettype wire

/* bench/rename_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_tb;

  localparam int    MAX_OPS       = 64;
  localparam int    CYCLES_PER_OP = 8;
  localparam int    TAIL_CYCLES   = 50;
  localparam string PATTERN_FILE  = "bench/rename_patterns.txt";

  logic                  clk;
  logic                  rst;
  logic                  req_valid;
  logic                  req_ready;
  rename_pkg::arch_idx_t req_dst;
  rename_pkg::arch_idx_t req_src1;
  rename_pkg::arch_idx_t req_src2;
  logic                  resp_valid;
  logic                  resp_ready;
  rename_pkg::phys_idx_t resp_src1_phys;
  rename_pkg::phys_idx_t resp_src2_phys;
  rename_pkg::phys_idx_t resp_new_phys;
  rename_pkg::phys_idx_t resp_old_phys;
  logic                  release_valid;
  rename_pkg::phys_idx_t release_phys;

  // One entry per pattern line
  bit op_is_release [MAX_OPS];
  int op_dst        [MAX_OPS];
  int op_src1       [MAX_OPS];
  int op_src2       [MAX_OPS];
  int op_hold       [MAX_OPS];
  int exp_src1      [MAX_OPS];
  int exp_src2      [MAX_OPS];
  int exp_new       [MAX_OPS];
  int exp_old       [MAX_OPS];

  int num_ops       = 0;
  int error_count   = 0;
  int rename_count  = 0;
  int release_count = 0;
  int cycle_count   = 0;
  int cycle_limit   = `RENAME_NUM_PHYS + TAIL_CYCLES;
  // Free registers expected in the list
  int free_cnt      = `RENAME_NUM_PHYS - `RENAME_NUM_ARCH;

  rename_top rename_top_inst (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_dst        (req_dst),
    .req_src1       (req_src1),
    .req_src2       (req_src2),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_src1_phys (resp_src1_phys),
    .resp_src2_phys (resp_src2_phys),
    .resp_new_phys  (resp_new_phys),
    .resp_old_phys  (resp_old_phys),
    .release_valid  (release_valid),
    .release_phys   (release_phys)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the rename stage stopped responding", cycle_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic load_patterns(output bit ok);
    int            fd;
    int            code;
    logic [7:0]    tag;
    logic [1023:0] skip_line;
    bit            done;
    ok   = 1'b1;
    done = 1'b0;
    fd   = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", PATTERN_FILE);
      ok = 1'b0;
    end else begin
      while (!done && ok) begin
        code = $fscanf(fd, "%s", tag);
        if (code != 1) begin
          done = 1'b1;
        end else if (tag == "#") begin
          code = $fgets(skip_line, fd);
        end else if (num_ops >= MAX_OPS) begin
          $display("Pattern file holds more than %0d operations", MAX_OPS);
          ok = 1'b0;
        end else if (tag == "R") begin
          code = $fscanf(fd, "%d %d %d %d %d %d %d %d", op_dst[num_ops], op_src1[num_ops],
                         op_src2[num_ops], op_hold[num_ops], exp_src1[num_ops],
                         exp_src2[num_ops], exp_new[num_ops], exp_old[num_ops]);
          op_is_release[num_ops] = 1'b0;
          num_ops++;
          if (code != 8) begin
            $display("Malformed rename line in the pattern file");
            ok = 1'b0;
          end
        end else if (tag == "F") begin
          code = $fscanf(fd, "%d", exp_new[num_ops]);
          op_is_release[num_ops] = 1'b1;
          num_ops++;
          if (code != 1) begin
            $display("Malformed release line in the pattern file");
            ok = 1'b0;
          end
        end else begin
          $display("Unknown operation in the pattern file");
          ok = 1'b0;
        end
      end
      $fclose(fd);
    end
  endtask

  // No request may be accepted while the sweep runs
  // A request is kept pending so an early accept shows up
  task automatic check_init_sweep();
    req_valid = 1'b1;
    repeat (`RENAME_NUM_PHYS) begin
      @(negedge clk);
      if (req_ready !== 1'b0) report_mismatch("req_ready", 0, int'(req_ready));
      if (resp_valid !== 1'b0) report_mismatch("resp_valid", 0, int'(resp_valid));
    end
  endtask

  task automatic check_response(input int idx);
    if (resp_valid !== 1'b1) report_mismatch("resp_valid", 1, int'(resp_valid));
    if (resp_src1_phys !== rename_pkg::phys_idx_t'(exp_src1[idx]))
      report_mismatch("resp_src1_phys", exp_src1[idx], int'(resp_src1_phys));
    if (resp_src2_phys !== rename_pkg::phys_idx_t'(exp_src2[idx]))
      report_mismatch("resp_src2_phys", exp_src2[idx], int'(resp_src2_phys));
    if (resp_new_phys !== rename_pkg::phys_idx_t'(exp_new[idx]))
      report_mismatch("resp_new_phys", exp_new[idx], int'(resp_new_phys));
    if (resp_old_phys !== rename_pkg::phys_idx_t'(exp_old[idx]))
      report_mismatch("resp_old_phys", exp_old[idx], int'(resp_old_phys));
  endtask

  task automatic run_rename(input int idx);
    int h;
    @(posedge clk);
    #2;
    release_valid = 1'b0;
    req_valid     = 1'b1;
    req_dst       = rename_pkg::arch_idx_t'(op_dst[idx]);
    req_src1      = rename_pkg::arch_idx_t'(op_src1[idx]);
    req_src2      = rename_pkg::arch_idx_t'(op_src2[idx]);
    resp_ready    = (op_hold[idx] == 0);
    @(negedge clk);
    while (req_ready !== 1'b1) begin
      @(negedge clk);
    end
    // Accepted on this edge
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    @(negedge clk);
    check_response(idx);
    // Stalled response must hold and block new requests
    for (h = 0; h < op_hold[idx]; h++) begin
      @(negedge clk);
      check_response(idx);
      if (req_ready !== 1'b0) report_mismatch("req_ready", 0, int'(req_ready));
    end
    if (op_hold[idx] > 0) begin
      @(posedge clk);
      #2;
      resp_ready = 1'b1;
    end
    free_cnt--;
    rename_count++;
  endtask

  task automatic run_release(input int idx);
    @(posedge clk);
    #2;
    release_valid = 1'b0;
    // Exhausted free list keeps requests out
    if (free_cnt == 0) begin
      @(negedge clk);
      if (req_ready !== 1'b0) report_mismatch("req_ready", 0, int'(req_ready));
      @(posedge clk);
      #2;
    end
    release_valid = 1'b1;
    release_phys  = rename_pkg::phys_idx_t'(exp_new[idx]);
    free_cnt++;
    release_count++;
  endtask

  initial begin
    int i;
    bit load_ok;
    clk           = 1'b0;
    rst           = 1'b1;
    req_valid     = 1'b0;
    req_dst       = '0;
    req_src1      = '0;
    req_src2      = '0;
    resp_ready    = 1'b1;
    release_valid = 1'b0;
    release_phys  = '0;
    load_patterns(load_ok);
    if (!load_ok) begin
      $display("Result: FAILED");
      $finish;
    end else begin
      cycle_limit = `RENAME_NUM_PHYS + CYCLES_PER_OP * num_ops + TAIL_CYCLES;
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;
      check_init_sweep();
      for (i = 0; i < num_ops; i++) begin
        if (op_is_release[i]) begin
          run_release(i);
        end else begin
          run_rename(i);
        end
      end
      @(posedge clk);
      #2;
      release_valid = 1'b0;
      repeat (2) @(posedge clk);
      $display("Renames: %0d, releases: %0d, errors: %0d",
               rename_count, release_count, error_count);
      if (error_count == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/rename_pkg.sv
src/rename_if.sv
src/free_list.sv
src/map_table.sv
src/init_counter.sv
src/rename_ctrl.sv
src/rename_top.sv
bench/rename_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module rename_tb -Mdir obj_dir

output=$(./obj_dir/Vrename_tb)
echo "$output"

if echo "$output" | grep -q "^Result: PASSED$"; then
  exit 0
fi
exit 1

/* bench/rename_patterns.txt */
# R dst src1 src2 hold exp_src1 exp_src2 exp_new exp_old  (decimal, hold = resp_ready low cycles)
# F phys  (commit releases a physical register id)
R 1 2 3 0 2 3 16 1
R 2 1 1 0 16 16 17 2
R 1 1 2 0 16 17 18 16
R 1 1 0 3 18 0 19 18
R 3 3 3 0 3 3 20 3
R 4 3 1 0 20 19 21 4
R 5 4 2 2 21 17 22 5
R 15 14 15 0 14 15 23 15
R 15 15 5 0 23 22 24 23
R 0 15 0 0 24 0 25 0
R 6 7 8 0 7 8 26 6
R 7 6 0 1 26 25 27 7
R 2 2 7 0 17 27 28 17
R 8 9 10 0 9 10 29 8
R 9 8 2 0 29 28 30 9
R 1 1 9 0 19 30 31 19
F 1
R 10 1 10 0 31 10 1 10
F 2
F 16
F 18
R 11 10 11 0 1 11 2 11
F 3
R 12 11 12 0 2 12 16 12
R 13 12 13 0 16 13 18 13
R 14 13 14 0 18 14 3 14
